//--- aggregatingPermutePipeline.f
+incdir+include
hdl/permutePipelinePkg.sv
hdl/syncFifo.sv
hdl/botPermuterWithMultiFIFO.sv
hdl/aggregatingPipeline.sv
hdl/resultsReadPort.sv
hdl/aggregatingPermutePipeline.sv
verification/aggregatingPermutePipelineTb.sv

//--- Makefile
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal
TOP      ?= aggregatingPermutePipelineTb
FILELIST ?= aggregatingPermutePipeline.f
BUILD    ?= obj_dir
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search the log for the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- include/pipelineReference.svh
`ifndef PIPELINE_REFERENCE_SVH
`define PIPELINE_REFERENCE_SVH

`include "permutePipeline_defines.svh"

// Swap by flipping both index bits wherever they differ
function automatic logic [`BOT_WIDTH-1:0] swapVariablePair(
    input logic [`BOT_WIDTH-1:0] bot,
    input logic [`PERMUTE_WIDTH-1:0] code
);
    int a;
    int b;
    int src;
    a = int'(code[2:0]);
    b = int'(code[5:3]);
    swapVariablePair = bot;
    if (a != 7 && b != 7 && a != b) begin
        for (int k = 0; k < `BOT_WIDTH; k++) begin
            src = k;
            if (((k >> a) & 1) != ((k >> b) & 1)) begin
                src = k ^ ((1 << a) | (1 << b));
            end
            swapVariablePair[k] = bot[src];
        end
    end
endfunction

function automatic bit isSubsetOfTop(input logic [`BOT_WIDTH-1:0] top, input logic [`BOT_WIDTH-1:0] bot);
    return (bot & ~top) == '0;
endfunction

function automatic logic [34:0] termOfBot(input logic [`BOT_WIDTH-1:0] top, input logic [`BOT_WIDTH-1:0] bot);
    logic [`BOT_WIDTH-1:0] rest;
    int nibbles;
    rest = top & ~bot;
    nibbles = 0;
    for (int n = 0; n < `BOT_WIDTH / 4; n++) begin
        if (rest[4*n +: 4] != 4'h0) begin
            nibbles++;
        end
    end
    return 35'(1) << nibbles;
endfunction

// Adds one raw lane bot with its code to a batch result
function automatic void accumulateExpected(
    input logic [`BOT_WIDTH-1:0] top,
    input logic [`BOT_WIDTH-1:0] bot,
    input logic [`PERMUTE_WIDTH-1:0] code,
    inout logic [`PCOEFF_SUM_BITWIDTH-1:0] sum,
    inout logic [`PCOEFF_COUNT_BITWIDTH-1:0] count
);
    logic [`BOT_WIDTH-1:0] swapped;
    swapped = swapVariablePair(bot, code);
    if (isSubsetOfTop(top, swapped)) begin
        sum = sum + `PCOEFF_SUM_BITWIDTH'(termOfBot(top, swapped));
        count = count + 1'b1;
    end
endfunction

function automatic logic [31:0] lcgNext(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
endfunction

`endif

//--- verification/aggregatingPermutePipelineTb.sv
`timescale 1ns/1ns
`include "permutePipeline_defines.svh"

module aggregatingPermutePipelineTb;
    import permutePipelinePkg::*;

    `include "pipelineReference.svh"

    localparam int LANES = `NUMBER_OF_PERMUTATORS;
    localparam int PRESSURE_BATCHES = 14;
    localparam int TOTAL_BOTS = 12 + (10 + 10) + (9 + 11) + (40 + 40)
        + (3 + 2 + 0 + 5 + 1 + 2 + 4) + PRESSURE_BATCHES * (3 + 3);
    localparam int WATCHDOG_CYCLES = TOTAL_BOTS * 20 + 2000;

    logic clk;
    logic reset;
    logic [`BOT_WIDTH-1:0] topFunction;
    laneBot_t bots [LANES];
    logic [LANES-1:0] batchesDone;
    logic [LANES-1:0] slowDownInputs;
    logic cyc;
    logic stb;
    logic we;
    logic [1:0] adr;
    logic [31:0] datWrite;
    logic [31:0] datRead;
    logic ack;

    int errors = 0;
    int checks = 0;
    string testName = "";
    logic [31:0] laneState [LANES];
    logic [`PCOEFF_SUM_BITWIDTH-1:0] batchSum;
    logic [`PCOEFF_COUNT_BITWIDTH-1:0] batchCount;
    // Expected results, one per batch, in issue order
    pcoeffResult_t expected [$];
    int drainRequests = 0;
    bit checkLevels = 1'b0;
    int batchesClosed = 0;
    int slowHolds = 0;

    aggregatingPermutePipeline dut0 (
        .clk(clk),
        .reset(reset),
        .top(topFunction),
        .bots(bots),
        .batchesDone(batchesDone),
        .slowDownInputs(slowDownInputs),
        .cyc(cyc),
        .stb(stb),
        .we(we),
        .adr(adr),
        .datWrite(datWrite),
        .datRead(datRead),
        .ack(ack)
    );

    always #20 clk = ~clk;

    function automatic logic [`BOT_WIDTH-1:0] randomWord(inout logic [31:0] state);
        logic [`BOT_WIDTH-1:0] word;
        for (int i = 0; i < `BOT_WIDTH / 16; i++) begin
            state = lcgNext(state);
            word[16*i +: 16] = state[31:16];
        end
        return word;
    endfunction

    // Mix of sparse subsets, dense subsets, zero bots and random bots
    function automatic logic [`BOT_WIDTH-1:0] nextBot(inout logic [31:0] state);
        logic [`BOT_WIDTH-1:0] r1;
        logic [`BOT_WIDTH-1:0] r2;
        logic [`BOT_WIDTH-1:0] r3;
        logic [1:0] kind;
        state = lcgNext(state);
        kind = state[29:28];
        r1 = randomWord(state);
        r2 = randomWord(state);
        r3 = randomWord(state);
        case (kind)
            2'd0: nextBot = topFunction & r1 & r2 & r3;
            2'd1: nextBot = topFunction & r1;
            2'd2: nextBot = '0;
            default: nextBot = r1;
        endcase
    endfunction

    // One Wishbone classic cycle, ack expected exactly one cycle after the strobe
    task automatic busAccess(input bit write, input logic [1:0] address,
                             input logic [31:0] data, output logic [31:0] readData);
        int waitCycles;
        @(posedge clk);
        #1;
        cyc = 1'b1;
        stb = 1'b1;
        we = write;
        adr = address;
        datWrite = data;
        waitCycles = 0;
        do begin
            @(posedge clk);
            #1;
            waitCycles++;
        end while (!ack && waitCycles < 8);
        checks++;
        if (!ack) begin
            errors++;
            $display("%s: no ack for Wishbone access to address %0d", testName, address);
        end else if (waitCycles != 1) begin
            errors++;
            $display("%s: ack came %0d cycles after the strobe", testName, waitCycles);
        end
        readData = datRead;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        @(posedge clk);
        #1;
        if (ack) begin
            errors++;
            $display("%s: ack stayed high for a second cycle", testName);
        end
    endtask

    // Source reacts to slowDownInputs one cycle late, inside the 2-cycle allowance
    task automatic driveLane(input int lane, input int count, input bit randomCodes);
        logic [31:0] state;
        logic [`BOT_WIDTH-1:0] word;
        logic [`PERMUTE_WIDTH-1:0] code;
        bit holdOff;
        int sent;
        state = laneState[lane];
        holdOff = 1'b0;
        sent = 0;
        while (sent < count) begin
            @(posedge clk);
            #1;
            if (holdOff) begin
                bots[lane].valid = 1'b0;
                slowHolds++;
            end else begin
                word = nextBot(state);
                state = lcgNext(state);
                // No-swap codes: index 7, or both indices equal
                code = randomCodes ? state[21:16] : (state[20] ? 6'o77 : 6'o22);
                bots[lane] = '{valid: 1'b1, permute: code, bot: word};
                accumulateExpected(topFunction, word, code, batchSum, batchCount);
                sent++;
            end
            holdOff = slowDownInputs[lane];
        end
        @(posedge clk);
        #1;
        bots[lane].valid = 1'b0;
        batchesDone[lane] = 1'b1;
        @(posedge clk);
        #1;
        batchesDone[lane] = 1'b0;
        laneState[lane] = state;
    endtask

    task automatic waitBatchClose();
        do begin
            @(posedge clk);
            #1;
        end while (!dut0.permutedBot.last);
        batchesClosed++;
    endtask

    task automatic runBatch(input int count0, input int count1, input bit randomCodes);
        batchSum = '0;
        batchCount = '0;
        fork
            driveLane(0, count0, randomCodes);
            driveLane(1, count1, randomCodes);
        join
        expected.push_back('{sum: batchSum, count: batchCount});
        waitBatchClose();
    endtask

    task automatic requestDrain(input int count, input bit levels);
        checkLevels = levels;
        drainRequests = count;
        wait (drainRequests == 0);
    endtask

    task automatic waitStatusLevel(input int level, input int maxPolls, output logic [31:0] status);
        int polls;
        polls = 0;
        do begin
            busAccess(1'b0, 2'd0, '0, status);
            polls++;
        end while (status[31:8] < 24'(level) && polls < maxPolls);
    endtask

    // Reads one result per request and compares it with the model
    initial begin : compareResults
        logic [31:0] status;
        logic [31:0] countWord;
        logic [31:0] lowWord;
        logic [31:0] highWord;
        pcoeffResult_t want;
        int polls;
        forever begin
            wait (drainRequests > 0);
            polls = 0;
            do begin
                busAccess(1'b0, 2'd0, '0, status);
                polls++;
            end while (!status[0] && polls < 200);
            checks++;
            if (!status[0]) begin
                errors++;
                $display("%s: no result became available on the Wishbone port", testName);
            end else if (expected.size() == 0) begin
                errors++;
                $display("%s: a result arrived that no batch accounts for", testName);
            end else begin
                if (checkLevels && status[31:8] != 24'(expected.size())) begin
                    errors++;
                    $display("mismatch %s level: expected %0d, actual %0d",
                             testName, expected.size(), status[31:8]);
                end
                busAccess(1'b0, 2'd1, '0, countWord);
                busAccess(1'b0, 2'd2, '0, lowWord);
                busAccess(1'b0, 2'd3, '0, highWord);
                want = expected.pop_front();
                checks += 2;
                if (countWord != 32'(want.count)) begin
                    errors++;
                    $display("mismatch %s count: expected %0d, actual %0d",
                             testName, want.count, countWord);
                end
                if ({highWord, lowWord} != 64'(want.sum)) begin
                    errors++;
                    $display("mismatch %s sum: expected %0h, actual %0h",
                             testName, want.sum, {highWord, lowWord});
                end
            end
            drainRequests--;
        end
    end

    initial begin : stimulus
        logic [31:0] lcgState;
        logic [31:0] word;
        int closedBefore;
        clk = 1'b0;
        reset = 1'b1;
        batchesDone = '0;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = 2'd0;
        datWrite = '0;
        for (int i = 0; i < LANES; i++) begin
            bots[i] = '0;
        end
        lcgState = 32'd46;
        topFunction = randomWord(lcgState) | randomWord(lcgState) | randomWord(lcgState);
        laneState[0] = lcgNext(lcgState);
        laneState[1] = ~laneState[0];
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (2) @(posedge clk);

        testName = "reset status";
        busAccess(1'b0, 2'd0, '0, word);
        checks += 2;
        if (word != 32'd0) begin
            errors++;
            $display("mismatch %s: expected %0h, actual %0h", testName, 32'd0, word);
        end
        if (slowDownInputs != '0) begin
            errors++;
            $display("%s: slowDownInputs high after reset", testName);
        end
        // Write is ignored, empty pop read returns zero
        busAccess(1'b1, 2'd3, 32'hFFFF_FFFF, word);
        busAccess(1'b0, 2'd3, '0, word);
        checks++;
        if (word != 32'd0) begin
            errors++;
            $display("mismatch %s empty pop: expected %0h, actual %0h", testName, 32'd0, word);
        end

        testName = "single lane no swap";
        runBatch(12, 0, 1'b0);
        requestDrain(1, 1'b0);

        testName = "random codes";
        runBatch(10, 10, 1'b1);
        runBatch(9, 11, 1'b1);
        requestDrain(2, 1'b0);

        testName = "lane slow-down";
        slowHolds = 0;
        runBatch(40, 40, 1'b1);
        checks++;
        if (slowHolds == 0) begin
            errors++;
            $display("%s: slowDownInputs never asserted during long bursts", testName);
        end
        requestDrain(1, 1'b0);

        testName = "queued batches";
        runBatch(3, 2, 1'b1);
        runBatch(0, 0, 1'b1);
        runBatch(5, 1, 1'b0);
        runBatch(2, 4, 1'b1);
        waitStatusLevel(expected.size(), 20, word);
        checks++;
        if (word[31:8] != 24'(expected.size())) begin
            errors++;
            $display("mismatch %s level: expected %0d, actual %0d",
                     testName, expected.size(), word[31:8]);
        end
        requestDrain(4, 1'b1);

        testName = "result back-pressure";
        closedBefore = batchesClosed;
        fork
            begin
                for (int b = 0; b < PRESSURE_BATCHES; b++) begin
                    runBatch(3, 3, 1'b1);
                end
            end
            begin
                waitStatusLevel(`RESULT_SLOWDOWN_LEVEL + 1, 1000, word);
                checks++;
                if (word[31:8] <= 24'(`RESULT_SLOWDOWN_LEVEL)) begin
                    errors++;
                    $display("%s: results FIFO never passed its slow-down level", testName);
                end
                repeat (40) @(posedge clk);
                checks++;
                if (batchesClosed - closedBefore >= PRESSURE_BATCHES) begin
                    errors++;
                    $display("%s: permuter did not stall on a full results queue", testName);
                end
                requestDrain(PRESSURE_BATCHES, 1'b0);
            end
        join

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Bound scaled to the number of bots driven
    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles in test %s",
                 WATCHDOG_CYCLES, testName);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- hdl/aggregatingPermutePipeline.sv
`timescale 1ns/1ns
`include "permutePipeline_defines.svh"

module aggregatingPermutePipeline (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [`BOT_WIDTH-1:0]              top,
    input  permutePipelinePkg::laneBot_t       bots [`NUMBER_OF_PERMUTATORS],
    input  logic [`NUMBER_OF_PERMUTATORS-1:0]  batchesDone,
    output logic [`NUMBER_OF_PERMUTATORS-1:0]  slowDownInputs,
    input  logic                               cyc,
    input  logic                               stb,
    input  logic                               we,
    input  logic [1:0]                         adr,
    input  logic [31:0]                        datWrite,
    output logic [31:0]                        datRead,
    output logic                               ack
);
    import permutePipelinePkg::*;

    localparam int RESULT_USED_BITS = `RESULT_FIFO_DEPTH_LOG2 + 1;

    logic computePipeReset;
    logic resultsFifoReset;
    logic requestSlowDownPre;
    logic requestSlowDown;
    permutedBot_t permutedBot;
    logic resultsValid;
    pcoeffResult_t result;
    logic resultsValidD;
    pcoeffResult_t resultD;
    pcoeffResult_t fifoHead;
    logic fifoEmpty;
    logic fifoPop;
    logic [RESULT_USED_BITS-1:0] fifoUsedw;

    // Local reset copies for the pipeline and the results FIFO
    always_ff @(posedge clk) begin
        computePipeReset <= reset;
        resultsFifoReset <= reset;
    end

    botPermuterWithMultiFIFO permuter (
        .clk(clk),
        .reset(reset),
        .bots(bots),
        .batchesDone(batchesDone),
        .slowDownInputs(slowDownInputs),
        .requestSlowDown(requestSlowDown),
        .permutedBot(permutedBot)
    );

    aggregatingPipeline computePipe (
        .clk(clk),
        .reset(computePipeReset),
        .top(top),
        .bot(permutedBot),
        .resultsValid(resultsValid),
        .result(result)
    );

    // Register stage between pipeline and results FIFO
    always_ff @(posedge clk) begin
        if (computePipeReset) begin
            resultsValidD <= 1'b0;
        end else begin
            resultsValidD <= resultsValid;
        end
        resultD <= result;
    end

    syncFifo #(
        .WIDTH($bits(pcoeffResult_t)),
        .DEPTH_LOG2(`RESULT_FIFO_DEPTH_LOG2)
    ) resultsFifo (
        .clk(clk),
        .reset(resultsFifoReset),
        .writeEnable(resultsValidD),
        .dataIn(resultD),
        .readRequest(fifoPop),
        .dataOut(fifoHead),
        .usedw(fifoUsedw),
        .empty(fifoEmpty)
    );

    // Two registers of slack on the fill-level path back to the permuter
    always_ff @(posedge clk) begin
        if (resultsFifoReset) begin
            requestSlowDownPre <= 1'b0;
            requestSlowDown <= 1'b0;
        end else begin
            requestSlowDownPre <= fifoUsedw > RESULT_USED_BITS'(`RESULT_SLOWDOWN_LEVEL);
            requestSlowDown <= requestSlowDownPre;
        end
    end

    resultsReadPort readPort (
        .clk(clk),
        .reset(reset),
        .cyc(cyc),
        .stb(stb),
        .we(we),
        .adr(adr),
        .datWrite(datWrite),
        .datRead(datRead),
        .ack(ack),
        .fifoHead(fifoHead),
        .fifoEmpty(fifoEmpty),
        .fifoUsedw(fifoUsedw),
        .fifoPop(fifoPop)
    );

endmodule

//--- hdl/resultsReadPort.sv
`timescale 1ns/1ns
`include "permutePipeline_defines.svh"

module resultsReadPort (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               cyc,
    input  logic                               stb,
    input  logic                               we,
    input  logic [1:0]                         adr,
    input  logic [31:0]                        datWrite,
    output logic [31:0]                        datRead,
    output logic                               ack,
    input  permutePipelinePkg::pcoeffResult_t  fifoHead,
    input  logic                               fifoEmpty,
    input  logic [`RESULT_FIFO_DEPTH_LOG2:0]   fifoUsedw,
    output logic                               fifoPop
);
    localparam int USED_BITS = `RESULT_FIFO_DEPTH_LOG2 + 1;

    logic request;
    logic popArmed;

    // A held strobe gets one ack, then a gap
    assign request = cyc && stb && !ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            ack <= 1'b0;
            popArmed <= 1'b0;
        end else begin
            ack <= request;
            popArmed <= request && !we && adr == 2'd3 && !fifoEmpty;
        end
    end

    // Write data is accepted but has no target
    always_ff @(posedge clk) begin
        if (request && !we) begin
            case (adr)
                2'd0: datRead <= {{(24 - USED_BITS){1'b0}}, fifoUsedw, 7'd0, !fifoEmpty};
                2'd1: datRead <= 32'(fifoHead.count);
                2'd2: datRead <= fifoHead.sum[31:0];
                default: datRead <= fifoEmpty ? '0 : 32'(fifoHead.sum[`PCOEFF_SUM_BITWIDTH-1:32]);
            endcase
        end else if (request) begin
            datRead <= '0;
        end
    end

    // Head leaves the FIFO at the end of the ack cycle
    assign fifoPop = popArmed;

endmodule

//--- hdl/aggregatingPipeline.sv
`timescale 1ns/1ns
`include "permutePipeline_defines.svh"

module aggregatingPipeline (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [`BOT_WIDTH-1:0]             top,
    input  permutePipelinePkg::permutedBot_t  bot,
    output logic                              resultsValid,
    output permutePipelinePkg::pcoeffResult_t result
);
    localparam int TERM_WIDTH = 35;
    localparam int NIBBLE_BITS = 6;

    logic s1Valid;
    logic s1Last;
    logic s1Subset;
    logic [`BOT_WIDTH-1:0] s1Remainder;
    logic s2Valid;
    logic s2Last;
    logic s2Subset;
    logic [NIBBLE_BITS-1:0] s2Nibbles;
    logic contributes;
    logic [TERM_WIDTH-1:0] term;
    logic [`PCOEFF_SUM_BITWIDTH-1:0] accSum;
    logic [`PCOEFF_SUM_BITWIDTH-1:0] nextSum;
    logic [`PCOEFF_COUNT_BITWIDTH-1:0] accCount;
    logic [`PCOEFF_COUNT_BITWIDTH-1:0] nextCount;

    function automatic logic [NIBBLE_BITS-1:0] countNibbles(input logic [`BOT_WIDTH-1:0] word);
        countNibbles = '0;
        for (int n = 0; n < `BOT_WIDTH / 4; n++) begin
            countNibbles = countNibbles + NIBBLE_BITS'(|word[4*n +: 4]);
        end
    endfunction

    // Stage 1: subset test and top-and-not-bot
    always_ff @(posedge clk) begin
        if (reset) begin
            s1Valid <= 1'b0;
            s1Last <= 1'b0;
        end else begin
            s1Valid <= bot.valid;
            s1Last <= bot.last;
        end
        s1Subset <= (bot.bot & ~top) == '0;
        s1Remainder <= top & ~bot.bot;
    end

    // Stage 2: nonzero nibbles of the remainder
    always_ff @(posedge clk) begin
        if (reset) begin
            s2Valid <= 1'b0;
            s2Last <= 1'b0;
        end else begin
            s2Valid <= s1Valid;
            s2Last <= s1Last;
        end
        s2Subset <= s1Subset;
        s2Nibbles <= countNibbles(s1Remainder);
    end

    // Stage 3: term and accumulation
    assign contributes = s2Valid && s2Subset;
    assign term = contributes ? (TERM_WIDTH'(1) << s2Nibbles) : '0;
    assign nextSum = accSum + `PCOEFF_SUM_BITWIDTH'(term);
    assign nextCount = accCount + `PCOEFF_COUNT_BITWIDTH'(contributes);

    always_ff @(posedge clk) begin
        if (reset) begin
            accSum <= '0;
            accCount <= '0;
            resultsValid <= 1'b0;
        end else begin
            resultsValid <= s2Last;
            if (s2Last) begin
                accSum <= '0;
                accCount <= '0;
            end else begin
                accSum <= nextSum;
                accCount <= nextCount;
            end
        end
    end

    // Last bot's own term is part of the emitted result
    always_ff @(posedge clk) begin
        if (s2Last) begin
            result <= '{sum: nextSum, count: nextCount};
        end
    end

    countNoWrap: assert property (@(posedge clk) disable iff (reset)
        contributes |-> accCount != '1);

endmodule

//--- hdl/botPermuterWithMultiFIFO.sv
`timescale 1ns/1ns
`include "permutePipeline_defines.svh"

module botPermuterWithMultiFIFO (
    input  logic                                clk,
    input  logic                                reset,
    input  permutePipelinePkg::laneBot_t        bots [`NUMBER_OF_PERMUTATORS],
    input  logic [`NUMBER_OF_PERMUTATORS-1:0]   batchesDone,
    output logic [`NUMBER_OF_PERMUTATORS-1:0]   slowDownInputs,
    input  logic                                requestSlowDown,
    output permutePipelinePkg::permutedBot_t    permutedBot
);
    localparam int LANES = `NUMBER_OF_PERMUTATORS;
    localparam int LANE_BITS = (LANES > 1) ? $clog2(LANES) : 1;
    localparam int ENTRY_WIDTH = `PERMUTE_WIDTH + `BOT_WIDTH;
    localparam int USED_BITS = `LANE_FIFO_DEPTH_LOG2 + 1;

    logic [ENTRY_WIDTH-1:0] laneHead [LANES];
    logic [USED_BITS-1:0] laneUsed [LANES];
    // Entries of the current batch still queued, valid once doneFlag is set
    logic [USED_BITS-1:0] pending [LANES];
    logic [LANES-1:0] laneEmpty;
    logic [LANES-1:0] doneFlag;
    logic [LANES-1:0] drained;
    logic [LANES-1:0] drainedAfter;
    logic [LANES-1:0] eligible;
    logic [LANES-1:0] pop;
    logic [LANE_BITS-1:0] rrLane;
    logic [LANE_BITS-1:0] grantLane;
    logic grantValid;
    logic issue;
    logic batchEnd;
    logic [ENTRY_WIDTH-1:0] selected;
    logic outValid;
    logic outLast;
    logic [`BOT_WIDTH-1:0] outBot;

    // Bit k of the result takes bit k' of the input, k' = k with bits a and b exchanged
    function automatic logic [`BOT_WIDTH-1:0] swapVariables(
        input logic [`BOT_WIDTH-1:0] word,
        input logic [`PERMUTE_WIDTH-1:0] code
    );
        logic [2:0] a;
        logic [2:0] b;
        logic [6:0] idx;
        logic [6:0] src;
        a = code[2:0];
        b = code[5:3];
        swapVariables = word;
        if (a != 3'd7 && b != 3'd7 && a != b) begin
            for (int k = 0; k < `BOT_WIDTH; k++) begin
                idx = 7'(k);
                src = idx;
                src[a] = idx[b];
                src[b] = idx[a];
                swapVariables[k] = word[src];
            end
        end
    endfunction

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        syncFifo #(
            .WIDTH(ENTRY_WIDTH),
            .DEPTH_LOG2(`LANE_FIFO_DEPTH_LOG2)
        ) laneFifo (
            .clk(clk),
            .reset(reset),
            .writeEnable(bots[i].valid),
            .dataIn({bots[i].permute, bots[i].bot}),
            .readRequest(pop[i]),
            .dataOut(laneHead[i]),
            .usedw(laneUsed[i]),
            .empty(laneEmpty[i])
        );

        // Drained lanes hold back their next-batch bots until the batch closes
        assign drained[i] = doneFlag[i] && pending[i] == '0;
        assign eligible[i] = !laneEmpty[i] && !drained[i];
        assign pop[i] = issue && grantValid && grantLane == LANE_BITS'(i);
        assign drainedAfter[i] = doneFlag[i] && pending[i] == USED_BITS'(pop[i]);

        laneNotFull: assert property (@(posedge clk) disable iff (reset)
            bots[i].valid |-> laneUsed[i] != USED_BITS'(1 << `LANE_FIFO_DEPTH_LOG2));

        // Only one batch end per lane may be outstanding
        singleDone: assert property (@(posedge clk) disable iff (reset)
            batchesDone[i] |-> !doneFlag[i] || (issue && batchEnd));
    end

    always_comb begin
        int candidate;
        grantValid = 1'b0;
        grantLane = rrLane;
        for (int k = 1; k <= LANES; k++) begin
            candidate = (int'(rrLane) + k) % LANES;
            if (!grantValid && eligible[candidate]) begin
                grantValid = 1'b1;
                grantLane = LANE_BITS'(candidate);
            end
        end
    end

    assign selected = laneHead[grantLane];
    // With every lane drained and nothing left, a bot-free last marker goes out
    assign issue = !requestSlowDown && (grantValid || &drained);
    assign batchEnd = &drainedAfter;

    always_ff @(posedge clk) begin
        if (reset) begin
            slowDownInputs <= '0;
            doneFlag <= '0;
            for (int i = 0; i < LANES; i++) begin
                pending[i] <= '0;
            end
        end else begin
            for (int i = 0; i < LANES; i++) begin
                slowDownInputs[i] <= laneUsed[i] > USED_BITS'(`LANE_SLOWDOWN_LEVEL);
                if (batchesDone[i]) begin
                    doneFlag[i] <= 1'b1;
                    pending[i] <= laneUsed[i] - USED_BITS'(pop[i]);
                end else if (issue && batchEnd) begin
                    doneFlag[i] <= 1'b0;
                end else if (pop[i] && doneFlag[i]) begin
                    pending[i] <= pending[i] - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            outValid <= 1'b0;
            outLast <= 1'b0;
            rrLane <= '0;
        end else begin
            outValid <= issue && grantValid;
            outLast <= issue && batchEnd;
            if (issue && grantValid) begin
                rrLane <= grantLane;
            end
        end
    end

    // Swap stage; the marker carries a zero bot with valid low
    always_ff @(posedge clk) begin
        if (issue) begin
            outBot <= grantValid ?
                swapVariables(selected[`BOT_WIDTH-1:0], selected[ENTRY_WIDTH-1:`BOT_WIDTH]) : '0;
        end
    end

    assign permutedBot = '{valid: outValid, last: outLast, bot: outBot};

endmodule

//--- hdl/syncFifo.sv
`timescale 1ns/1ns

module syncFifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH_LOG2 = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  writeEnable,
    input  logic [WIDTH-1:0]      dataIn,
    input  logic                  readRequest,
    output logic [WIDTH-1:0]      dataOut,
    output logic [DEPTH_LOG2:0]   usedw,
    output logic                  empty
);
    localparam int DEPTH = 1 << DEPTH_LOG2;

    logic [WIDTH-1:0] storage [DEPTH];
    logic [DEPTH_LOG2-1:0] writePtr;
    logic [DEPTH_LOG2-1:0] readPtr;

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            storage[writePtr] <= dataIn;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            writePtr <= '0;
            readPtr <= '0;
            usedw <= '0;
        end else begin
            if (writeEnable) begin
                writePtr <= writePtr + 1'b1;
            end
            if (readRequest) begin
                readPtr <= readPtr + 1'b1;
            end
            usedw <= usedw + (DEPTH_LOG2 + 1)'(writeEnable) - (DEPTH_LOG2 + 1)'(readRequest);
        end
    end

    // Fall-through: head entry is always on the output
    assign dataOut = storage[readPtr];
    assign empty = (usedw == '0);

    noOverflow: assert property (@(posedge clk) disable iff (reset)
        writeEnable |-> usedw != (DEPTH_LOG2 + 1)'(DEPTH));

    noUnderflow: assert property (@(posedge clk) disable iff (reset)
        readRequest |-> !empty);

endmodule

//--- hdl/permutePipelinePkg.sv
`include "permutePipeline_defines.svh"

package permutePipelinePkg;

    // One input lane word
    typedef struct packed {
        logic                      valid;
        logic [`PERMUTE_WIDTH-1:0] permute;
        logic [`BOT_WIDTH-1:0]     bot;
    } laneBot_t;

    // Merged stream after the variable swap
    typedef struct packed {
        logic                  valid;
        logic                  last;
        logic [`BOT_WIDTH-1:0] bot;
    } permutedBot_t;

    // Batch result, also the results FIFO word
    typedef struct packed {
        logic [`PCOEFF_SUM_BITWIDTH-1:0]   sum;
        logic [`PCOEFF_COUNT_BITWIDTH-1:0] count;
    } pcoeffResult_t;

endpackage

//--- include/permutePipeline_defines.svh
`ifndef PERMUTE_PIPELINE_DEFINES_SVH
`define PERMUTE_PIPELINE_DEFINES_SVH

// Lane count and word widths
`define NUMBER_OF_PERMUTATORS 2
`define BOT_WIDTH 128

// Low 3 bits pick variable a, high 3 bits pick variable b
`define PERMUTE_WIDTH 6

`define PCOEFF_COUNT_BITWIDTH 16
// A single term needs up to 35 bits (2**32 plus margin for the shift)
`define PCOEFF_SUM_BITWIDTH (`PCOEFF_COUNT_BITWIDTH + 35)

// Lane input buffering
`define LANE_FIFO_DEPTH_LOG2 4
`define LANE_SLOWDOWN_LEVEL 10

// Result buffering towards the host
`define RESULT_FIFO_DEPTH_LOG2 4
`define RESULT_SLOWDOWN_LEVEL 10

`endif
